//--- design/decode_pkg.sv
`default_nettype none

package decode_pkg;

    // ------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------
    localparam int NB_DATA         = 32;
    localparam int NB_REG_ADDRESS  = 5;
    localparam int NB_OP_FIELD     = 6;
    localparam int NB_IMMEDIATE    = 16;
    localparam int NB_JUMP_ADDRESS = 26;
    localparam int NB_FORWARD_SEL  = 2;
    localparam int N_REGISTERS     = 32;

    // ------------------------------------------------------------------
    // Instruction field positions (MSB of each field)
    // ------------------------------------------------------------------
    localparam int OP_MSB  = 31;
    localparam int RS_MSB  = 25;
    localparam int RT_MSB  = 20;
    localparam int RD_MSB  = 15;
    localparam int IMM_MSB = 15;

    typedef logic [NB_DATA-1:0]         data_t;
    typedef logic [NB_REG_ADDRESS-1:0]  reg_addr_t;
    typedef logic [NB_OP_FIELD-1:0]     op_field_t;
    typedef logic [NB_JUMP_ADDRESS-1:0] jump_addr_t;
    typedef logic [NB_DATA-1:0]         instruction_t;

    // Operand source select, ordered as the forwarding mux inputs
    typedef enum logic [NB_FORWARD_SEL-1:0] {
        FWD_REG    = 2'd0,
        FWD_EX_MEM = 2'd1,
        FWD_MEM_WB = 2'd2,
        FWD_ID_EX  = 2'd3
    } fwd_sel_t;

endpackage

`default_nettype wire

//--- design/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file
    import decode_pkg::*;
(
    input  wire logic      i_clock,
    input  wire logic      i_rst_n,

    // Operand and debug read ports
    input  wire reg_addr_t i_read_addr_a,
    input  wire reg_addr_t i_read_addr_b,
    input  wire reg_addr_t i_read_addr_debug,

    // Write port, driven from write back
    input  wire logic      i_write_enable,
    input  wire reg_addr_t i_write_addr,
    input  wire data_t     i_write_data,

    output data_t          o_read_data_a,
    output data_t          o_read_data_b,
    output data_t          o_read_data_debug
);

    data_t registers [N_REGISTERS];

    // Register 0 is hardwired to zero
    function automatic data_t read_word(input reg_addr_t addr, input data_t word);
        data_t value;
        value = '0;
        if (addr != '0) begin
            value = word;
        end
        return value;
    endfunction

    // ------------------------------------------------------------------
    // Write port
    // ------------------------------------------------------------------
    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            for (int idx = 0; idx < N_REGISTERS; idx++) begin
                registers[idx] <= '0;
            end
        end else if (i_write_enable && (i_write_addr != '0)) begin
            registers[i_write_addr] <= i_write_data;
        end
    end

    // ------------------------------------------------------------------
    // Read ports
    // ------------------------------------------------------------------
    // Same-cycle write to the read address still returns the old word,
    // MEM/WB forwarding supplies the new one
    always_comb begin
        o_read_data_a     = read_word(i_read_addr_a, registers[i_read_addr_a]);
        o_read_data_b     = read_word(i_read_addr_b, registers[i_read_addr_b]);
        o_read_data_debug = read_word(i_read_addr_debug,
                                      registers[i_read_addr_debug]);
    end

endmodule

`default_nettype wire

//--- design/forwarding_unit.sv
`timescale 1ns/1ps
`default_nettype none

module forwarding_unit
    import decode_pkg::*;
(
    // Source registers of the instruction in decode
    input  wire reg_addr_t i_rs,
    input  wire reg_addr_t i_rt,

    // Destinations of the later stages
    input  wire reg_addr_t i_rd_id_ex,
    input  wire reg_addr_t i_rd_ex_mem,
    input  wire reg_addr_t i_rd_mem_wb,

    input  wire logic      i_reg_write_id_ex,
    input  wire logic      i_reg_write_ex_mem,
    input  wire logic      i_reg_write_mem_wb,

    output fwd_sel_t       o_forward_a,
    output fwd_sel_t       o_forward_b
);

    // A stage forwards only if it writes a real register matching the source
    function automatic logic stage_match(
        input logic      write_enable,
        input reg_addr_t dest,
        input reg_addr_t src
    );
        return write_enable && (dest != '0) && (dest == src);
    endfunction

    // Youngest result wins
    function automatic fwd_sel_t priority_select(
        input logic hit_id_ex,
        input logic hit_ex_mem,
        input logic hit_mem_wb
    );
        fwd_sel_t sel;
        if (hit_id_ex) begin
            sel = FWD_ID_EX;
        end else if (hit_ex_mem) begin
            sel = FWD_EX_MEM;
        end else if (hit_mem_wb) begin
            sel = FWD_MEM_WB;
        end else begin
            sel = FWD_REG;
        end
        return sel;
    endfunction

    always_comb begin
        o_forward_a = priority_select(
            stage_match(i_reg_write_id_ex,  i_rd_id_ex,  i_rs),
            stage_match(i_reg_write_ex_mem, i_rd_ex_mem, i_rs),
            stage_match(i_reg_write_mem_wb, i_rd_mem_wb, i_rs)
        );
        o_forward_b = priority_select(
            stage_match(i_reg_write_id_ex,  i_rd_id_ex,  i_rt),
            stage_match(i_reg_write_ex_mem, i_rd_ex_mem, i_rt),
            stage_match(i_reg_write_mem_wb, i_rd_mem_wb, i_rt)
        );
    end

endmodule

`default_nettype wire

//--- design/instruction_decode.sv
`timescale 1ns/1ps
`default_nettype none

module instruction_decode
    import decode_pkg::*;
(
    input  wire logic         i_clock,
    input  wire logic         i_rst_n,
    input  wire instruction_t i_instruction,

    // Later stages, for forwarding
    input  wire logic         i_reg_write_id_ex,
    input  wire logic         i_reg_write_ex_mem,
    input  wire logic         i_reg_write_mem_wb,
    input  wire reg_addr_t    i_rd_id_ex,
    input  wire reg_addr_t    i_rd_ex_mem,
    input  wire reg_addr_t    i_rd_mem_wb,
    input  wire data_t        i_data_id_ex,
    input  wire data_t        i_data_ex_mem,
    input  wire data_t        i_data_mem_wb,

    // Write back into the register file
    input  wire data_t        i_write_back_data,
    input  wire reg_addr_t    i_write_back_addr,

    input  wire data_t        i_new_pc,
    input  wire logic         i_jump_or_branch,
    input  wire reg_addr_t    i_debug_addr,

    output data_t             o_debug_data,
    output data_t             o_cond_a,
    output data_t             o_cond_b,
    output jump_addr_t        o_jump_index,
    output data_t             o_operand_a,
    output data_t             o_operand_b,
    output data_t             o_immediate,
    output reg_addr_t         o_rs,
    output reg_addr_t         o_rt,
    output reg_addr_t         o_rd,
    output op_field_t         o_op_field
);

    reg_addr_t rs;
    reg_addr_t rt;
    data_t     reg_data_a;
    data_t     reg_data_b;
    data_t     fwd_data_a;
    data_t     fwd_data_b;
    fwd_sel_t  forward_a;
    fwd_sel_t  forward_b;

    function automatic data_t forward_mux(
        input fwd_sel_t sel,
        input data_t    reg_value,
        input data_t    id_ex_value,
        input data_t    ex_mem_value,
        input data_t    mem_wb_value
    );
        data_t value;
        case (sel)
            FWD_ID_EX:  value = id_ex_value;
            FWD_EX_MEM: value = ex_mem_value;
            FWD_MEM_WB: value = mem_wb_value;
            default:    value = reg_value;
        endcase
        return value;
    endfunction

    // ------------------------------------------------------------------
    // Field extraction
    // ------------------------------------------------------------------
    assign rs           = i_instruction[RS_MSB -: NB_REG_ADDRESS];
    assign rt           = i_instruction[RT_MSB -: NB_REG_ADDRESS];
    assign o_rs         = rs;
    assign o_rt         = rt;
    assign o_rd         = i_instruction[RD_MSB -: NB_REG_ADDRESS];
    assign o_op_field   = i_instruction[OP_MSB -: NB_OP_FIELD];
    assign o_jump_index = i_instruction[NB_JUMP_ADDRESS-1:0];

    // Sign extension of the 16-bit immediate
    assign o_immediate = {{(NB_DATA-NB_IMMEDIATE){i_instruction[IMM_MSB]}},
                          i_instruction[IMM_MSB -: NB_IMMEDIATE]};

    // ------------------------------------------------------------------
    // Register file and forwarding
    // ------------------------------------------------------------------
    register_file u_register_file (
        .i_clock           (i_clock),
        .i_rst_n           (i_rst_n),
        .i_read_addr_a     (rs),
        .i_read_addr_b     (rt),
        .i_read_addr_debug (i_debug_addr),
        .i_write_enable    (i_reg_write_mem_wb),
        .i_write_addr      (i_write_back_addr),
        .i_write_data      (i_write_back_data),
        .o_read_data_a     (reg_data_a),
        .o_read_data_b     (reg_data_b),
        .o_read_data_debug (o_debug_data)
    );

    forwarding_unit u_forwarding_unit (
        .i_rs               (rs),
        .i_rt               (rt),
        .i_rd_id_ex         (i_rd_id_ex),
        .i_rd_ex_mem        (i_rd_ex_mem),
        .i_rd_mem_wb        (i_rd_mem_wb),
        .i_reg_write_id_ex  (i_reg_write_id_ex),
        .i_reg_write_ex_mem (i_reg_write_ex_mem),
        .i_reg_write_mem_wb (i_reg_write_mem_wb),
        .o_forward_a        (forward_a),
        .o_forward_b        (forward_b)
    );

    assign fwd_data_a = forward_mux(forward_a, reg_data_a,
                                    i_data_id_ex, i_data_ex_mem, i_data_mem_wb);
    assign fwd_data_b = forward_mux(forward_b, reg_data_b,
                                    i_data_id_ex, i_data_ex_mem, i_data_mem_wb);

    // Return address replaces A for link, the compare keeps the register value
    assign o_operand_a = i_jump_or_branch ? i_new_pc : fwd_data_a;
    assign o_operand_b = fwd_data_b;
    assign o_cond_a    = fwd_data_a;
    assign o_cond_b    = fwd_data_b;

endmodule

`default_nettype wire

//--- design/id_ex_register.sv
`timescale 1ns/1ps
`default_nettype none

module id_ex_register
    import decode_pkg::*;
(
    input  wire logic      i_clock,
    input  wire logic      i_rst_n,

    // Decoded operands
    input  wire data_t     i_operand_a,
    input  wire data_t     i_operand_b,
    input  wire data_t     i_immediate,

    // Register addresses
    input  wire reg_addr_t i_rs,
    input  wire reg_addr_t i_rt,
    input  wire reg_addr_t i_rd,

    input  wire op_field_t i_op_field,

    output data_t          o_operand_a,
    output data_t          o_operand_b,
    output data_t          o_immediate,
    output reg_addr_t      o_rs,
    output reg_addr_t      o_rt,
    output reg_addr_t      o_rd,
    output op_field_t      o_op_field
);

    // ------------------------------------------------------------------
    // ID/EX stage register
    // ------------------------------------------------------------------
    // No stall input, a new instruction is captured every cycle
    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            o_operand_a <= '0;
            o_operand_b <= '0;
            o_immediate <= '0;
            o_rs        <= '0;
            o_rt        <= '0;
            o_rd        <= '0;
            o_op_field  <= '0;
        end else begin
            o_operand_a <= i_operand_a;
            o_operand_b <= i_operand_b;
            o_immediate <= i_immediate;
            o_rs        <= i_rs;
            o_rt        <= i_rt;
            o_rd        <= i_rd;
            o_op_field  <= i_op_field;
        end
    end

endmodule

`default_nettype wire

//--- design/decode_stage_top.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage_top
    import decode_pkg::*;
(
    input  wire logic         i_clock,
    input  wire logic         i_rst_n,
    input  wire instruction_t i_instruction,

    // Later stages
    input  wire logic         i_reg_write_id_ex,
    input  wire logic         i_reg_write_ex_mem,
    input  wire logic         i_reg_write_mem_wb,
    input  wire reg_addr_t    i_rd_id_ex,
    input  wire reg_addr_t    i_rd_ex_mem,
    input  wire reg_addr_t    i_rd_mem_wb,
    input  wire data_t        i_data_id_ex,
    input  wire data_t        i_data_ex_mem,
    input  wire data_t        i_data_mem_wb,

    // Write back
    input  wire data_t        i_write_back_data,
    input  wire reg_addr_t    i_write_back_addr,

    input  wire data_t        i_new_pc,
    input  wire logic         i_jump_or_branch,
    input  wire reg_addr_t    i_debug_addr,

    // Same-cycle outputs
    output data_t             o_cond_a,
    output data_t             o_cond_b,
    output jump_addr_t        o_jump_index,
    output data_t             o_debug_data,

    // To execute, one cycle after decode
    output data_t             o_operand_a,
    output data_t             o_operand_b,
    output data_t             o_immediate,
    output reg_addr_t         o_rs,
    output reg_addr_t         o_rt,
    output reg_addr_t         o_rd,
    output op_field_t         o_op_field
);

    data_t     dec_operand_a;
    data_t     dec_operand_b;
    data_t     dec_immediate;
    reg_addr_t dec_rs;
    reg_addr_t dec_rt;
    reg_addr_t dec_rd;
    op_field_t dec_op_field;

    instruction_decode u_instruction_decode (
        .i_clock            (i_clock),
        .i_rst_n            (i_rst_n),
        .i_instruction      (i_instruction),
        .i_reg_write_id_ex  (i_reg_write_id_ex),
        .i_reg_write_ex_mem (i_reg_write_ex_mem),
        .i_reg_write_mem_wb (i_reg_write_mem_wb),
        .i_rd_id_ex         (i_rd_id_ex),
        .i_rd_ex_mem        (i_rd_ex_mem),
        .i_rd_mem_wb        (i_rd_mem_wb),
        .i_data_id_ex       (i_data_id_ex),
        .i_data_ex_mem      (i_data_ex_mem),
        .i_data_mem_wb      (i_data_mem_wb),
        .i_write_back_data  (i_write_back_data),
        .i_write_back_addr  (i_write_back_addr),
        .i_new_pc           (i_new_pc),
        .i_jump_or_branch   (i_jump_or_branch),
        .i_debug_addr       (i_debug_addr),
        .o_debug_data       (o_debug_data),
        .o_cond_a           (o_cond_a),
        .o_cond_b           (o_cond_b),
        .o_jump_index       (o_jump_index),
        .o_operand_a        (dec_operand_a),
        .o_operand_b        (dec_operand_b),
        .o_immediate        (dec_immediate),
        .o_rs               (dec_rs),
        .o_rt               (dec_rt),
        .o_rd               (dec_rd),
        .o_op_field         (dec_op_field)
    );

    id_ex_register u_id_ex_register (
        .i_clock     (i_clock),
        .i_rst_n     (i_rst_n),
        .i_operand_a (dec_operand_a),
        .i_operand_b (dec_operand_b),
        .i_immediate (dec_immediate),
        .i_rs        (dec_rs),
        .i_rt        (dec_rt),
        .i_rd        (dec_rd),
        .i_op_field  (dec_op_field),
        .o_operand_a (o_operand_a),
        .o_operand_b (o_operand_b),
        .o_immediate (o_immediate),
        .o_rs        (o_rs),
        .o_rt        (o_rt),
        .o_rd        (o_rd),
        .o_op_field  (o_op_field)
    );

endmodule

`default_nettype wire

//--- verification/decode_checker.sv
`timescale 1ns/1ps
`default_nettype none

module decode_checker
    import decode_pkg::*;
(
    input  wire logic         i_clock,
    input  wire logic         i_rst_n,

    // Stimulus as the DUT sees it
    input  wire instruction_t i_instruction,
    input  wire logic         i_reg_write_id_ex,
    input  wire logic         i_reg_write_ex_mem,
    input  wire logic         i_reg_write_mem_wb,
    input  wire reg_addr_t    i_rd_id_ex,
    input  wire reg_addr_t    i_rd_ex_mem,
    input  wire reg_addr_t    i_rd_mem_wb,
    input  wire data_t        i_data_id_ex,
    input  wire data_t        i_data_ex_mem,
    input  wire data_t        i_data_mem_wb,
    input  wire data_t        i_write_back_data,
    input  wire reg_addr_t    i_write_back_addr,
    input  wire data_t        i_new_pc,
    input  wire logic         i_jump_or_branch,
    input  wire reg_addr_t    i_debug_addr,
    input  wire op_field_t    i_exp_op_field,
    input  wire data_t        i_exp_immediate,

    // DUT responses
    input  wire data_t        i_cond_a,
    input  wire data_t        i_cond_b,
    input  wire jump_addr_t   i_jump_index,
    input  wire data_t        i_debug_data,
    input  wire data_t        i_operand_a,
    input  wire data_t        i_operand_b,
    input  wire data_t        i_immediate,
    input  wire reg_addr_t    i_rs,
    input  wire reg_addr_t    i_rt,
    input  wire reg_addr_t    i_rd,
    input  wire op_field_t    i_op_field,

    output int                o_error_count,
    output int                o_check_count
);

    data_t        model [N_REGISTERS];
    instruction_t prev_instruction;
    data_t        exp_operand_a;
    data_t        exp_operand_b;
    data_t        exp_immediate;
    op_field_t    exp_op_field;
    int           error_count = 0;
    int           check_count = 0;

    assign o_error_count = error_count;
    assign o_check_count = check_count;

    // Register value, then older stages overridden by younger ones
    function automatic data_t expected_operand(input reg_addr_t src);
        data_t value;
        value = model[src];
        if (src != '0) begin
            if (i_reg_write_mem_wb && (i_rd_mem_wb == src)) value = i_data_mem_wb;
            if (i_reg_write_ex_mem && (i_rd_ex_mem == src)) value = i_data_ex_mem;
            if (i_reg_write_id_ex && (i_rd_id_ex == src)) value = i_data_id_ex;
        end
        return value;
    endfunction

    task automatic compare_value(input string name, input data_t actual, input data_t expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s is 0x%08h, expected 0x%08h",
                     $time, name, actual, expected);
        end
    endtask

    always @(posedge i_clock) begin
        if (!i_rst_n) begin
            for (int idx = 0; idx < N_REGISTERS; idx++) begin
                model[idx] = '0;
            end
            prev_instruction = '0;
            exp_operand_a    = '0;
            exp_operand_b    = '0;
            exp_immediate    = '0;
            exp_op_field     = '0;
        end else begin
            // Same-cycle outputs
            compare_value("o_cond_a", i_cond_a,
                          expected_operand(i_instruction[RS_MSB -: NB_REG_ADDRESS]));
            compare_value("o_cond_b", i_cond_b,
                          expected_operand(i_instruction[RT_MSB -: NB_REG_ADDRESS]));
            compare_value("o_jump_index", i_jump_index, i_instruction[NB_JUMP_ADDRESS-1:0]);
            compare_value("o_debug_data", i_debug_data, model[i_debug_addr]);

            // ID/EX outputs still hold the previous row
            compare_value("o_operand_a", i_operand_a, exp_operand_a);
            compare_value("o_operand_b", i_operand_b, exp_operand_b);
            compare_value("o_immediate", i_immediate, exp_immediate);
            compare_value("o_op_field", i_op_field, exp_op_field);
            compare_value("o_rs", i_rs, prev_instruction[RS_MSB -: NB_REG_ADDRESS]);
            compare_value("o_rt", i_rt, prev_instruction[RT_MSB -: NB_REG_ADDRESS]);
            compare_value("o_rd", i_rd, prev_instruction[RD_MSB -: NB_REG_ADDRESS]);

            // What this edge captures into ID/EX
            exp_operand_b = expected_operand(i_instruction[RT_MSB -: NB_REG_ADDRESS]);
            exp_operand_a = expected_operand(i_instruction[RS_MSB -: NB_REG_ADDRESS]);
            if (i_jump_or_branch) begin
                exp_operand_a = i_new_pc;
            end
            exp_immediate    = i_exp_immediate;
            exp_op_field     = i_exp_op_field;
            prev_instruction = i_instruction;

            // Write back lands at this edge, after the reads above
            if (i_reg_write_mem_wb && (i_write_back_addr != '0)) begin
                model[i_write_back_addr] = i_write_back_data;
            end
        end
    end

endmodule

`default_nettype wire

//--- verification/tb_decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_decode_stage
    import decode_pkg::*;
();

    localparam int CLK_PERIOD = 4;
    localparam int N_ROWS     = 20;

    typedef struct packed {
        instruction_t instr;
        logic [2:0]   write_en;
        reg_addr_t    rd_id_ex;
        reg_addr_t    rd_ex_mem;
        reg_addr_t    rd_mem_wb;
        logic         jump;
        reg_addr_t    debug_addr;
        op_field_t    exp_op;
        data_t        exp_imm;
    } row_t;

    logic         i_clock;
    logic         i_rst_n;
    instruction_t i_instruction;
    logic         i_reg_write_id_ex;
    logic         i_reg_write_ex_mem;
    logic         i_reg_write_mem_wb;
    reg_addr_t    i_rd_id_ex;
    reg_addr_t    i_rd_ex_mem;
    reg_addr_t    i_rd_mem_wb;
    data_t        i_data_id_ex;
    data_t        i_data_ex_mem;
    data_t        i_data_mem_wb;
    data_t        i_write_back_data;
    reg_addr_t    i_write_back_addr;
    data_t        i_new_pc;
    logic         i_jump_or_branch;
    reg_addr_t    i_debug_addr;
    data_t        o_cond_a;
    data_t        o_cond_b;
    jump_addr_t   o_jump_index;
    data_t        o_debug_data;
    data_t        o_operand_a;
    data_t        o_operand_b;
    data_t        o_immediate;
    reg_addr_t    o_rs;
    reg_addr_t    o_rt;
    reg_addr_t    o_rd;
    op_field_t    o_op_field;
    op_field_t    exp_op_field;
    data_t        exp_immediate;
    int           error_count;
    int           check_count;
    row_t         rows [N_ROWS];
    int           n_rows = 0;

    decode_stage_top dut0 (.*);

    decode_checker checker0 (
        .*,
        .i_exp_op_field  (exp_op_field),
        .i_exp_immediate (exp_immediate),
        .i_cond_a        (o_cond_a),
        .i_cond_b        (o_cond_b),
        .i_jump_index    (o_jump_index),
        .i_debug_data    (o_debug_data),
        .i_operand_a     (o_operand_a),
        .i_operand_b     (o_operand_b),
        .i_immediate     (o_immediate),
        .i_rs            (o_rs),
        .i_rt            (o_rt),
        .i_rd            (o_rd),
        .i_op_field      (o_op_field),
        .o_error_count   (error_count),
        .o_check_count   (check_count)
    );

    initial begin
        i_clock = 1'b0;
        forever #(CLK_PERIOD / 2) i_clock = ~i_clock;
    end

    // ------------------------------------------------------------------
    // Stimulus table
    // ------------------------------------------------------------------
    task automatic add_row(input instruction_t instr, input logic [2:0] write_en,
                           input reg_addr_t rd_id_ex, input reg_addr_t rd_ex_mem,
                           input reg_addr_t rd_mem_wb, input logic jump,
                           input reg_addr_t debug_addr, input op_field_t exp_op,
                           input data_t exp_imm);
        rows[n_rows] = {instr, write_en, rd_id_ex, rd_ex_mem, rd_mem_wb,
                        jump, debug_addr, exp_op, exp_imm};
        n_rows++;
    endtask

    // Each row holds the instruction, the enables {id_ex, ex_mem, mem_wb}, the rd of
    // id_ex, ex_mem and mem_wb, the jump flag, the debug address, the expected opcode
    // and the expected immediate
    task automatic build_table();
        // Reads after reset, write back, register 0
        add_row(32'h2022_0005, 3'b000, 5'd0, 5'd0, 5'd0, 1'b0, 5'd3, 6'h08, 32'h0000_0005);
        add_row(32'h2024_0010, 3'b001, 5'd0, 5'd0, 5'd1, 1'b0, 5'd1, 6'h08, 32'h0000_0010);
        add_row(32'h8C22_FFF0, 3'b001, 5'd0, 5'd0, 5'd2, 1'b0, 5'd1, 6'h23, 32'hFFFF_FFF0);
        add_row(32'hAC01_0004, 3'b001, 5'd0, 5'd0, 5'd0, 1'b0, 5'd2, 6'h2B, 32'h0000_0004);
        add_row(32'h2002_0001, 3'b000, 5'd0, 5'd0, 5'd0, 1'b0, 5'd0, 6'h08, 32'h0000_0001);
        // Forwarding priority, zero destination, disabled enables
        add_row(32'h00A6_3820, 3'b111, 5'd5, 5'd5, 5'd5, 1'b0, 5'd5, 6'h00, 32'h0000_3820);
        add_row(32'h00E5_4020, 3'b011, 5'd7, 5'd7, 5'd7, 1'b0, 5'd5, 6'h00, 32'h0000_4020);
        add_row(32'h0000_0820, 3'b111, 5'd0, 5'd0, 5'd0, 1'b0, 5'd7, 6'h00, 32'h0000_0820);
        add_row(32'h2022_0002, 3'b000, 5'd1, 5'd1, 5'd1, 1'b0, 5'd1, 6'h08, 32'h0000_0002);
        add_row(32'h0062_2020, 3'b010, 5'd0, 5'd2, 5'd0, 1'b0, 5'd2, 6'h00, 32'h0000_2020);
        // Jump and branch with link address on operand A
        add_row(32'h0D55_AA55, 3'b000, 5'd0, 5'd0, 5'd0, 1'b1, 5'd0, 6'h03, 32'hFFFF_AA55);
        add_row(32'h1022_FFFC, 3'b100, 5'd1, 5'd0, 5'd0, 1'b1, 5'd1, 6'h04, 32'hFFFF_FFFC);
        // Immediate sign extension and back-to-back traffic
        add_row(32'h0064_2820, 3'b001, 5'd0, 5'd0, 5'd3, 1'b0, 5'd5, 6'h00, 32'h0000_2820);
        add_row(32'h3464_7FFF, 3'b001, 5'd0, 5'd0, 5'd4, 1'b0, 5'd3, 6'h0D, 32'h0000_7FFF);
        add_row(32'h8C83_8000, 3'b000, 5'd0, 5'd0, 5'd0, 1'b0, 5'd4, 6'h23, 32'hFFFF_8000);
        add_row(32'h0064_3020, 3'b101, 5'd3, 5'd0, 5'd4, 1'b0, 5'd6, 6'h00, 32'h0000_3020);
        add_row(32'h00C3_3822, 3'b110, 5'd6, 5'd3, 5'd0, 1'b1, 5'd31, 6'h00, 32'h0000_3822);
        add_row(32'h0BFF_FFFF, 3'b001, 5'd0, 5'd0, 5'd31, 1'b1, 5'd31, 6'h02, 32'hFFFF_FFFF);
        add_row(32'h23FF_0000, 3'b000, 5'd0, 5'd0, 5'd0, 1'b0, 5'd31, 6'h08, 32'h0000_0000);
        add_row(32'h3C09_1234, 3'b010, 5'd0, 5'd9, 5'd0, 1'b0, 5'd9, 6'h0F, 32'h0000_1234);
    endtask

    task automatic apply_row(input row_t row);
        i_instruction = row.instr;
        {i_reg_write_id_ex, i_reg_write_ex_mem, i_reg_write_mem_wb} = row.write_en;
        i_rd_id_ex    = row.rd_id_ex;
        i_rd_ex_mem   = row.rd_ex_mem;
        i_rd_mem_wb   = row.rd_mem_wb;
        i_data_id_ex  = $urandom();
        i_data_ex_mem = $urandom();
        i_data_mem_wb = $urandom();
        // MEM/WB is the stage that writes back
        i_write_back_data = i_data_mem_wb;
        i_write_back_addr = row.rd_mem_wb;
        i_new_pc          = $urandom();
        i_jump_or_branch  = row.jump;
        i_debug_addr      = row.debug_addr;
        exp_op_field      = row.exp_op;
        exp_immediate     = row.exp_imm;
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------
    initial begin
        void'($urandom(41264));
        build_table();
        i_rst_n = 1'b0;
        // Nonzero decode and a write back while reset is held
        apply_row(rows[17]);
        repeat (2) @(posedge i_clock);
        @(negedge i_clock);
        i_rst_n = 1'b1;
        for (int i = 0; i < n_rows; i++) begin
            apply_row(rows[i]);
            @(negedge i_clock);
        end
        // Idle row lets the last instruction leave ID/EX
        apply_row('0);
        repeat (2) @(negedge i_clock);
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if ((error_count == 0) && (check_count > 0)) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #((N_ROWS + 10) * CLK_PERIOD);
        $display("Timeout: run did not finish within %0d ns", (N_ROWS + 10) * CLK_PERIOD);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
design/decode_pkg.sv
design/register_file.sv
design/forwarding_unit.sv
design/instruction_decode.sv
design/id_ex_register.sv
design/decode_stage_top.sv
verification/decode_checker.sv
verification/tb_decode_stage.sv
